/* Bender.yml */
package:
  name: collective_node

sources:
  - logic/collective_pkg.sv
  - logic/comm_table.sv
  - logic/flit_ingress.sv
  - logic/reduce_combiner.sv
  - logic/result_egress.sv
  - logic/collective_node.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/collective_node_tb.sv

/* dv/collective_node_vectors.svh */
`ifndef collective_node_vectors_svh
`define collective_node_vectors_svh

// One reduction per row. data and present list child 2 first and the local link last.
typedef struct packed {
	logic [comm_w-1:0]      comm;
	logic [comm_w-1:0]      late_comm;
	logic [op_w-1:0]        op;
	logic [seq_w-1:0]       seq;
	logic [3:0][data_w-1:0] data;
	logic [3:0]             present;
	logic                   foreign;
	logic                   exp_up;
	logic [data_w-1:0]      exp_data;
	logic [seq_w-1:0]       exp_seq;
	logic [rank_w-1:0]      exp_rank;
} vec_row_t;

vec_row_t vectors [10];
int       n_rows;

// valid, contextid, root, local_rank, children, lg_commsize, third, second, first
function automatic logic [comm_w-1:0] make_comm(input logic [7:0] ctx, input logic [8:0] root,
	input logic [8:0] rank, input logic [2:0] children);
	return {1'b1, ctx, root, rank, children, 4'd0, 27'd0};
endfunction

task automatic add_row(input logic [comm_w-1:0] comm, input logic [comm_w-1:0] late_comm,
	input logic [1:0] op, input logic [7:0] seq, input logic [3:0][31:0] data,
	input logic [3:0] present, input logic foreign, input logic exp_up,
	input logic [31:0] exp_data, input logic [7:0] exp_seq, input logic [8:0] exp_rank);
	vectors[n_rows].comm      = comm;
	vectors[n_rows].late_comm = late_comm;
	vectors[n_rows].op        = op;
	vectors[n_rows].seq       = seq;
	vectors[n_rows].data      = data;
	vectors[n_rows].present   = present;
	vectors[n_rows].foreign   = foreign;
	vectors[n_rows].exp_up    = exp_up;
	vectors[n_rows].exp_data  = exp_data;
	vectors[n_rows].exp_seq   = exp_seq;
	vectors[n_rows].exp_rank  = exp_rank;
	n_rows++;
endtask

task automatic fill_vectors();
	logic [comm_w-1:0] d_root;
	logic [comm_w-1:0] d_leaf;
	logic [comm_w-1:0] d_old;
	logic [comm_w-1:0] d_new;
	d_root = make_comm(8'h21, 9'd0, 9'd0, 3'b111);
	d_leaf = make_comm(8'h5a, 9'd3, 9'd12, 3'b111);
	d_old  = make_comm(8'h33, 9'd1, 9'd9, 3'b111);
	d_new  = make_comm(8'h44, 9'd6, 9'd6, 3'b011);
	n_rows = 0;
	// Root sums, the first one wraps
	add_row(d_root, d_root, op_sum, 8'h10, {32'h8000_0001, 32'h1234_5678, 32'h20, 32'hffff_fff0},
		4'b1111, 1'b0, 1'b0, 32'h9234_5689, 8'h10, 9'd0);
	add_row(d_root, d_root, op_sum, 8'h11, {32'd4, 32'd3, 32'd2, 32'd1},
		4'b1111, 1'b0, 1'b0, 32'd10, 8'h11, 9'd0);
	// Leaf node, child 0 first sends a flit of another context
	add_row(d_leaf, d_leaf, op_max, 8'h20, {32'h1, 32'h7fff_ffff, 32'hffff_0000, 32'h100},
		4'b1111, 1'b1, 1'b1, 32'hffff_0000, 8'h20, 9'd12);
	add_row(d_leaf, d_leaf, op_min, 8'h21, {32'h600, 32'h8000_0000, 32'h400, 32'h500},
		4'b1111, 1'b1, 1'b1, 32'h400, 8'h21, 9'd12);
	add_row(d_leaf, d_leaf, op_sum, 8'h22, {4{32'h8000_0000}},
		4'b1111, 1'b0, 1'b1, 32'h0, 8'h22, 9'd12);
	// New descriptor arrives halfway through
	add_row(d_old, d_new, op_max, 8'h30, {32'd7, 32'd3, 32'd9, 32'd5},
		4'b1111, 1'b0, 1'b1, 32'd9, 8'h30, 9'd9);
	add_row(d_new, d_new, op_or, 8'h31, {32'h0, 32'h00f0_0000, 32'h0000_0f00, 32'h0000_000f},
		4'b0111, 1'b0, 1'b0, 32'h00f0_0f0f, 8'h31, 9'd0);
	// Child 2 is outside the mask, its flit stays parked
	add_row(d_new, d_new, op_or, 8'h32, {32'hffff_ffff, 32'h4, 32'h2, 32'h1},
		4'b1111, 1'b0, 1'b0, 32'h7, 8'h32, 9'd0);
	add_row(d_new, d_new, op_min, 8'h33, {32'h0, 32'd5, 32'd20, 32'd10},
		4'b0111, 1'b0, 1'b0, 32'd5, 8'h33, 9'd0);
endtask

`endif

/* dv/collective_node_tb.sv */
module collective_node_tb import collective_pkg::*; ();

	localparam int wait_limit = 400;

	logic                           clk = 1'b0;
	logic                           rst_n;
	logic [comm_w-1:0]              newcomm;
	logic [flit_w-1:0]              local_flit;
	logic [flit_w-1:0]              child_flit_0;
	logic [flit_w-1:0]              child_flit_1;
	logic [flit_w-1:0]              child_flit_2;
	logic                           local_valid;
	logic                           child_valid_0;
	logic                           child_valid_1;
	logic                           child_valid_2;
	logic                           local_ready;
	logic                           child_ready_0;
	logic                           child_ready_1;
	logic                           child_ready_2;
	logic [flit_w-1:0]              up_flit;
	logic                           up_valid;
	logic                           up_ready;
	logic [data_w-1:0]              result_data;
	logic [op_w-1:0]                result_op;
	logic [seq_w-1:0]               result_seq;
	logic                           result_valid;
	logic                           result_ready;
	int                             n_seen;
	logic                           up_stalled;
	logic                           res_stalled;
	logic [flit_w-1:0]              up_held;
	logic [op_w+seq_w+data_w-1:0]   res_held;

	`include "collective_node_vectors.svh"

	collective_node collective_node_i (.*);

	always #20 clk = ~clk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else
			stop_run($sformatf("Fail at %0t: %s expected %0h, got %0h", $time, name, expected,
				actual));
	endtask

	function automatic logic [flit_w-1:0] make_flit(input logic [7:0] ctx, input logic [8:0] rank,
		input logic [1:0] op, input logic [7:0] seq, input logic [31:0] payload);
		return {1'b1, ctx, rank, op, seq, payload};
	endfunction

	// Chosen so that it would win the reduction if it were not dropped
	function automatic logic [data_w-1:0] foreign_payload(input logic [op_w-1:0] op);
		return (op == op_min) ? 32'h0 : 32'hffff_ffff;
	endfunction

	function automatic logic link_ready(input int link);
		case (link)
			0: return local_ready;
			1: return child_ready_0;
			2: return child_ready_1;
			default: return child_ready_2;
		endcase
	endfunction

	task automatic set_link(input int link, input logic [flit_w-1:0] flit, input logic valid);
		case (link)
			0: begin
				local_flit  <= flit;
				local_valid <= valid;
			end
			1: begin
				child_flit_0  <= flit;
				child_valid_0 <= valid;
			end
			2: begin
				child_flit_1  <= flit;
				child_valid_1 <= valid;
			end
			default: begin
				child_flit_2  <= flit;
				child_valid_2 <= valid;
			end
		endcase
	endtask

	task automatic send_flit(input int link, input logic [flit_w-1:0] flit);
		int waited;
		waited = 0;
		set_link(link, flit, 1'b1);
		@(posedge clk);
		while (!link_ready(link)) begin
			if (waited == wait_limit)
				stop_run($sformatf("Timed out waiting for link %0d to accept a flit", link));
			waited++;
			@(posedge clk);
		end
		set_link(link, '0, 1'b0);
	endtask

	task automatic drive_row_link(input vec_row_t row, input int link);
		logic [ctx_w-1:0] ctx;
		ctx = row.comm[comm_ctx_lo +: ctx_w];
		if (row.present[link]) begin
			if (row.foreign && link == 1)
				send_flit(link, make_flit(ctx ^ 8'hff, 9'd200, row.op, row.seq,
					foreign_payload(row.op)));
			send_flit(link, make_flit(ctx, 9'(100 + link), row.op, row.seq, row.data[link]));
			if (link == 0)
				newcomm <= row.late_comm;
		end
	endtask

	task automatic collect_result(input vec_row_t row);
		int   waited;
		logic done;
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			@(posedge clk);
			// The other port must stay quiet for the whole reduction
			if (row.exp_up)
				check_value("result_valid", 0, result_valid);
			else
				check_value("up_valid", 0, up_valid);
			done = row.exp_up ? (up_valid && up_ready) : (result_valid && result_ready);
			if (!done && waited == wait_limit)
				stop_run("Timed out waiting for the reduction result");
			waited++;
		end
		if (row.exp_up) begin
			check_value("up_flit valid", 1, up_flit[flit_valid_bit]);
			check_value("up_flit context_id", row.comm[comm_ctx_lo +: ctx_w],
				up_flit[flit_ctx_lo +: ctx_w]);
			check_value("up_flit src_rank", row.exp_rank, up_flit[flit_rank_lo +: rank_w]);
			check_value("up_flit op", row.op, up_flit[flit_op_lo +: op_w]);
			check_value("up_flit seq", row.exp_seq, up_flit[flit_seq_lo +: seq_w]);
			check_value("up_flit payload", row.exp_data, up_flit[flit_payload_lo +: data_w]);
		end else begin
			check_value("result_data", row.exp_data, result_data);
			check_value("result_op", row.op, result_op);
			check_value("result_seq", row.exp_seq, result_seq);
		end
		for (int k = 0; k < n_child; k++) begin
			if (row.present[k + 1] && !row.comm[comm_children_lo + k])
				check_value($sformatf("child_ready_%0d", k), 0, link_ready(k + 1));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, stalled values must hold
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			up_stalled  <= 1'b0;
			res_stalled <= 1'b0;
			n_seen      <= 0;
		end else begin
			if (up_stalled) begin
				check_value("up_valid", 1, up_valid);
				check_value("up_flit", up_held, up_flit);
			end
			if (res_stalled) begin
				check_value("result_valid", 1, result_valid);
				check_value("result_op/seq/data", res_held, {result_op, result_seq, result_data});
			end
			up_stalled  <= up_valid && !up_ready;
			res_stalled <= result_valid && !result_ready;
			up_held     <= up_flit;
			res_held    <= {result_op, result_seq, result_data};
			if ((up_valid && up_ready) || (result_valid && result_ready))
				n_seen <= n_seen + 1;
		end
	end

	// Random back-pressure on both output ports
	initial begin
		up_ready     = 1'b0;
		result_ready = 1'b0;
		void'($urandom(32'h47264802));
		forever begin
			@(posedge clk);
			up_ready     <= ($urandom % 4) != 0;
			result_ready <= ($urandom % 3) != 0;
		end
	end

	initial begin
		vec_row_t row;
		rst_n         = 1'b0;
		newcomm       = '0;
		local_flit    = '0;
		local_valid   = 1'b0;
		child_flit_0  = '0;
		child_valid_0 = 1'b0;
		child_flit_1  = '0;
		child_valid_1 = 1'b0;
		child_flit_2  = '0;
		child_valid_2 = 1'b0;
		fill_vectors();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < n_rows; r++) begin
			row = vectors[r];
			@(posedge clk);
			check_value("results delivered", r, n_seen);
			newcomm <= row.comm;
			// Descriptor is stored on the next edge
			@(posedge clk);
			fork
				drive_row_link(row, 0);
				drive_row_link(row, 1);
				drive_row_link(row, 2);
				drive_row_link(row, 3);
			join
			collect_result(row);
		end
		@(posedge clk);
		check_value("results delivered", n_rows, n_seen);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* logic/collective_node.sv */
module collective_node import collective_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [comm_w-1:0] newcomm,
	input  logic [flit_w-1:0] local_flit,
	input  logic              local_valid,
	output logic              local_ready,
	input  logic [flit_w-1:0] child_flit_0,
	input  logic              child_valid_0,
	output logic              child_ready_0,
	input  logic [flit_w-1:0] child_flit_1,
	input  logic              child_valid_1,
	output logic              child_ready_1,
	input  logic [flit_w-1:0] child_flit_2,
	input  logic              child_valid_2,
	output logic              child_ready_2,
	output logic [flit_w-1:0] up_flit,
	output logic              up_valid,
	input  logic              up_ready,
	output logic [data_w-1:0] result_data,
	output logic [op_w-1:0]   result_op,
	output logic [seq_w-1:0]  result_seq,
	output logic              result_valid,
	input  logic              result_ready
);

	logic               configured;
	logic               busy;
	logic [ctx_w-1:0]   context_id;
	logic [rank_w-1:0]  local_rank;
	logic [n_child-1:0] child_mask;
	logic               is_root;
	logic [flit_w-1:0]  head_flit [4];
	logic [3:0]         head_valid;
	logic [3:0]         take;
	logic               comb_valid;
	logic               comb_ready;
	logic [data_w-1:0]  comb_data;
	logic [op_w-1:0]    comb_op;
	logic [seq_w-1:0]   comb_seq;

	comm_table comm_table_i (
		.clk, .rst_n, .newcomm, .busy, .configured,
		.context_id, .local_rank, .child_mask, .is_root
	);

	////////////////////////////////////////////////////////////////////////////
	// Link buffers, slot 0 local and slots 1..3 children
	////////////////////////////////////////////////////////////////////////////

	flit_ingress local_ingress_i (
		.clk, .rst_n, .configured, .context_id,
		.in_flit(local_flit), .in_valid(local_valid), .in_ready(local_ready),
		.head_flit(head_flit[0]), .head_valid(head_valid[0]), .take(take[0])
	);

	flit_ingress child_ingress_0_i (
		.clk, .rst_n, .configured, .context_id,
		.in_flit(child_flit_0), .in_valid(child_valid_0), .in_ready(child_ready_0),
		.head_flit(head_flit[1]), .head_valid(head_valid[1]), .take(take[1])
	);

	flit_ingress child_ingress_1_i (
		.clk, .rst_n, .configured, .context_id,
		.in_flit(child_flit_1), .in_valid(child_valid_1), .in_ready(child_ready_1),
		.head_flit(head_flit[2]), .head_valid(head_valid[2]), .take(take[2])
	);

	flit_ingress child_ingress_2_i (
		.clk, .rst_n, .configured, .context_id,
		.in_flit(child_flit_2), .in_valid(child_valid_2), .in_ready(child_ready_2),
		.head_flit(head_flit[3]), .head_valid(head_valid[3]), .take(take[3])
	);

	reduce_combiner reduce_combiner_i (
		.clk, .rst_n, .child_mask,
		.head_flit_0(head_flit[0]), .head_flit_1(head_flit[1]),
		.head_flit_2(head_flit[2]), .head_flit_3(head_flit[3]),
		.head_valid_0(head_valid[0]), .head_valid_1(head_valid[1]),
		.head_valid_2(head_valid[2]), .head_valid_3(head_valid[3]),
		.take_0(take[0]), .take_1(take[1]), .take_2(take[2]), .take_3(take[3]),
		.busy, .comb_valid, .comb_data, .comb_op, .comb_seq, .comb_ready
	);

	result_egress result_egress_i (
		.clk, .rst_n, .is_root, .local_rank, .context_id,
		.comb_valid, .comb_data, .comb_op, .comb_seq, .comb_ready,
		.up_flit, .up_valid, .up_ready,
		.result_data, .result_op, .result_seq, .result_valid, .result_ready
	);

endmodule

/* logic/collective_pkg.sv */
package collective_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int ctx_w    = 8;
	localparam int rank_w   = 9;
	localparam int op_w     = 2;
	localparam int seq_w    = 8;
	localparam int data_w   = 32;
	localparam int n_child  = 3;
	localparam int lgsize_w = 4;

	////////////////////////////////////////////////////////////////////////////
	// Reduce flit
	////////////////////////////////////////////////////////////////////////////

	// valid | context_id | src_rank | op | seq | payload
	localparam int flit_w = 1 + ctx_w + rank_w + op_w + seq_w + data_w;

	localparam int flit_payload_lo = 0;
	localparam int flit_seq_lo     = flit_payload_lo + data_w;
	localparam int flit_op_lo      = flit_seq_lo + seq_w;
	localparam int flit_rank_lo    = flit_op_lo + op_w;
	localparam int flit_ctx_lo     = flit_rank_lo + rank_w;
	localparam int flit_valid_bit  = flit_ctx_lo + ctx_w;

	////////////////////////////////////////////////////////////////////////////
	// Communicator descriptor
	////////////////////////////////////////////////////////////////////////////

	// valid | contextid | root | local_rank | children | lg_commsize | third | second | first
	localparam int comm_w = 1 + ctx_w + 2 * rank_w + n_child + lgsize_w + 3 * rank_w;

	localparam int comm_first_lo    = 0;
	localparam int comm_second_lo   = comm_first_lo + rank_w;
	localparam int comm_third_lo    = comm_second_lo + rank_w;
	localparam int comm_lgsize_lo   = comm_third_lo + rank_w;
	localparam int comm_children_lo = comm_lgsize_lo + lgsize_w;
	localparam int comm_rank_lo     = comm_children_lo + n_child;
	localparam int comm_root_lo     = comm_rank_lo + rank_w;
	localparam int comm_ctx_lo      = comm_root_lo + rank_w;
	localparam int comm_valid_bit   = comm_ctx_lo + ctx_w;

	// Reduce operations
	localparam logic [op_w-1:0] op_sum = 2'd0;
	localparam logic [op_w-1:0] op_max = 2'd1;
	localparam logic [op_w-1:0] op_min = 2'd2;
	localparam logic [op_w-1:0] op_or  = 2'd3;

endpackage

/* logic/comm_table.sv */
module comm_table import collective_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [comm_w-1:0]  newcomm,
	input  logic               busy,
	output logic               configured,
	output logic [ctx_w-1:0]   context_id,
	output logic [rank_w-1:0]  local_rank,
	output logic [n_child-1:0] child_mask,
	output logic               is_root
);

	logic [comm_w-1:0] comm_q;
	logic              loaded_q;
	logic              configured_q;
	logic              load;

	// Only swap descriptors between reductions
	assign load = newcomm[comm_valid_bit] && !busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			comm_q <= '0;
		end else if (load) begin
			comm_q <= newcomm;
		end
	end

	// configured trails the first store by one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			loaded_q     <= 1'b0;
			configured_q <= 1'b0;
		end else begin
			if (load) begin
				loaded_q <= 1'b1;
			end
			configured_q <= loaded_q;
		end
	end

	assign configured = configured_q;
	assign context_id = comm_q[comm_ctx_lo +: ctx_w];
	assign local_rank = comm_q[comm_rank_lo +: rank_w];
	assign child_mask = comm_q[comm_children_lo +: n_child];
	assign is_root    = comm_q[comm_root_lo +: rank_w] == comm_q[comm_rank_lo +: rank_w];

	// Configured node either waits on children or is the root
	a_has_role: assert property (
		@(posedge clk) disable iff (!rst_n)
		configured |-> (|child_mask || is_root)
	) else $error("comm_table: configured node has no children and no role");

endmodule

/* logic/flit_ingress.sv */
module flit_ingress import collective_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              configured,
	input  logic [ctx_w-1:0]  context_id,
	input  logic [flit_w-1:0] in_flit,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [flit_w-1:0] head_flit,
	output logic              head_valid,
	input  logic              take
);

	logic [flit_w-1:0] head_q;
	logic              head_valid_q;
	logic              accept;
	logic              keep;

	// Free slot, or the slot empties this cycle
	assign in_ready = configured && (!head_valid_q || take);
	assign accept   = in_valid && in_ready;

	// Foreign context is swallowed here
	assign keep = in_flit[flit_valid_bit]
		&& in_flit[flit_ctx_lo +: ctx_w] == context_id;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_valid_q <= 1'b0;
		end else if (accept) begin
			head_valid_q <= keep;
		end else if (take) begin
			head_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && keep) begin
			head_q <= in_flit;
		end
	end

	assign head_flit  = head_q;
	assign head_valid = head_valid_q;

	// Combiner may only pull a buffered flit
	a_take_has_head: assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> head_valid_q
	) else $error("flit_ingress: take without a buffered flit");

	// Link sources hold the flit while stalled
	a_src_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_flit)
	) else $error("flit_ingress: source changed a stalled flit");

endmodule

/* logic/reduce_combiner.sv */
module reduce_combiner import collective_pkg::*; (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [n_child-1:0] child_mask,
	input  logic [flit_w-1:0]  head_flit_0,
	input  logic [flit_w-1:0]  head_flit_1,
	input  logic [flit_w-1:0]  head_flit_2,
	input  logic [flit_w-1:0]  head_flit_3,
	input  logic               head_valid_0,
	input  logic               head_valid_1,
	input  logic               head_valid_2,
	input  logic               head_valid_3,
	output logic               take_0,
	output logic               take_1,
	output logic               take_2,
	output logic               take_3,
	output logic               busy,
	output logic               comb_valid,
	output logic [data_w-1:0]  comb_data,
	output logic [op_w-1:0]    comb_op,
	output logic [seq_w-1:0]   comb_seq,
	input  logic               comb_ready
);

	logic [flit_w-1:0] heads [4];
	logic [3:0]        head_vld;
	logic [3:0]        required;
	logic [3:0]        take_vec;
	logic              complete;
	logic              fire;
	logic              heads_agree;
	logic [op_w-1:0]   op_sel;
	logic [data_w-1:0] acc;
	logic              comb_valid_q;
	logic [data_w-1:0] comb_data_q;
	logic [op_w-1:0]   comb_op_q;
	logic [seq_w-1:0]  comb_seq_q;

	function automatic logic [data_w-1:0] apply_op(
		input logic [op_w-1:0]   op,
		input logic [data_w-1:0] a,
		input logic [data_w-1:0] b
	);
		case (op)
			op_sum:  apply_op = a + b;
			op_max:  apply_op = (a > b) ? a : b;
			op_min:  apply_op = (a < b) ? a : b;
			op_or:   apply_op = a | b;
			default: apply_op = a;
		endcase
	endfunction

	// Slot 0 is the local injector, slots 1..3 the children
	assign heads    = '{head_flit_0, head_flit_1, head_flit_2, head_flit_3};
	assign head_vld = {head_valid_3, head_valid_2, head_valid_1, head_valid_0};
	assign required = {child_mask, 1'b1};

	assign complete = &(head_vld | ~required);
	assign fire     = complete && comb_ready;
	assign take_vec = fire ? required : 4'b0000;
	assign {take_3, take_2, take_1, take_0} = take_vec;

	////////////////////////////////////////////////////////////////////////////
	// Fold the payloads, local flit names the op
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		op_sel      = heads[0][flit_op_lo +: op_w];
		acc         = heads[0][flit_payload_lo +: data_w];
		heads_agree = 1'b1;
		for (int i = 1; i < 4; i++) begin
			if (required[i]) begin
				acc = apply_op(op_sel, acc, heads[i][flit_payload_lo +: data_w]);
				if (heads[i][flit_op_lo +: op_w] != op_sel
					|| heads[i][flit_seq_lo +: seq_w] != heads[0][flit_seq_lo +: seq_w]) begin
					heads_agree = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			comb_valid_q <= 1'b0;
		end else if (fire) begin
			comb_valid_q <= 1'b1;
		end else if (comb_ready) begin
			comb_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			comb_data_q <= acc;
			comb_op_q   <= op_sel;
			comb_seq_q  <= heads[0][flit_seq_lo +: seq_w];
		end
	end

	// Held from first arrival until the egress has the result
	assign busy       = |(head_vld & required) || comb_valid_q;
	assign comb_valid = comb_valid_q;
	assign comb_data  = comb_data_q;
	assign comb_op    = comb_op_q;
	assign comb_seq   = comb_seq_q;

	a_heads_agree: assert property (
		@(posedge clk) disable iff (!rst_n)
		fire |-> heads_agree
	) else $error("reduce_combiner: contributions disagree on seq or op");

endmodule

/* logic/result_egress.sv */
module result_egress import collective_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              is_root,
	input  logic [rank_w-1:0] local_rank,
	input  logic [ctx_w-1:0]  context_id,
	input  logic              comb_valid,
	input  logic [data_w-1:0] comb_data,
	input  logic [op_w-1:0]   comb_op,
	input  logic [seq_w-1:0]  comb_seq,
	output logic              comb_ready,
	output logic [flit_w-1:0] up_flit,
	output logic              up_valid,
	input  logic              up_ready,
	output logic [data_w-1:0] result_data,
	output logic [op_w-1:0]   result_op,
	output logic [seq_w-1:0]  result_seq,
	output logic              result_valid,
	input  logic              result_ready
);

	logic              out_valid_q;
	logic              to_root_q;
	logic [data_w-1:0] data_q;
	logic [op_w-1:0]   op_q;
	logic [seq_w-1:0]  seq_q;
	logic [ctx_w-1:0]  ctx_q;
	logic [rank_w-1:0] rank_q;
	logic              drain;
	logic              load;

	assign drain      = to_root_q ? result_ready : up_ready;
	assign comb_ready = !out_valid_q || drain;
	assign load       = comb_valid && comb_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid_q <= 1'b0;
		end else if (load) begin
			out_valid_q <= 1'b1;
		end else if (drain) begin
			out_valid_q <= 1'b0;
		end
	end

	// Rank and context snapshot, so a later descriptor cannot touch this result
	always_ff @(posedge clk) begin
		if (load) begin
			to_root_q <= is_root;
			data_q    <= comb_data;
			op_q      <= comb_op;
			seq_q     <= comb_seq;
			ctx_q     <= context_id;
			rank_q    <= local_rank;
		end
	end

	assign up_valid     = out_valid_q && !to_root_q;
	assign up_flit      = {1'b1, ctx_q, rank_q, op_q, seq_q, data_q};
	assign result_valid = out_valid_q && to_root_q;
	assign result_data  = data_q;
	assign result_op    = op_q;
	assign result_seq   = seq_q;

	// Combiner holds its result while stalled
	a_comb_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		comb_valid && !comb_ready |=> comb_valid && $stable(comb_data)
			&& $stable(comb_op) && $stable(comb_seq)
	) else $error("result_egress: stalled combined result changed");

endmodule

/* src.f */
+incdir+dv
logic/collective_pkg.sv
logic/comm_table.sv
logic/flit_ingress.sv
logic/reduce_combiner.sv
logic/result_egress.sv
logic/collective_node.sv
dv/collective_node_tb.sv
